/* list.f */
+incdir+.
mbfTypesPkg.sv
pipeCtrlPkg.sv
topCycleCounter.sv
pipeFlowFsm.sv
bitCompareStage.sv
sumAccumulator.sv
mbfPermutePipeline.sv
tbChecker.sv
tbMbfPipeline.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tbMbfPipeline
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSTEXT = Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tbMbfPipeline.sv */
`timescale 1ns/1ns
`include "mbfPipe_defs.svh"

module tbMbfPipeline
    import mbfTypesPkg::*;
    import pipeCtrlPkg::*;
();

    localparam int numTests = 18;
    localparam int waitLimit = 200;
    localparam int kindTop = 0;
    localparam int kindSub = 1;   // bot inside the top
    localparam int kindOut = 2;   // bot with a bit outside the top
    localparam int kindNul = 3;   // empty bot
    localparam int kindPlan [numTests] = '{kindTop, kindSub, kindSub, kindOut, kindNul, kindSub,
                                           kindTop, kindOut, kindSub, kindSub, kindTop, kindTop,
                                           kindSub, kindOut, kindSub, kindNul, kindSub, kindTop};

    logic        clock;
    logic        rst;
    logic        inputValid;
    logic        startNewTop;
    mbfWord      mbfIn;
    logic        inputReady;
    logic        outputValid;
    logic        outputReady;
    pipeResult   result;
    stageTag     tagOut;
    logic [39:0] testName [numTests];
    pipeResult   expResult [numTests];
    stageTag     expTag [numTests];
    mbfWord      wordTable [numTests];
    logic        topTable [numTests];
    int          checkedCount;
    int          errorCount;
    logic        timedOut;
    logic [31:0] lfsrState = 32'he1c1_314f;

    always #4 clock = ~clock;

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic stepBit();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic mbfWord randomWord();
        mbfWord w;
        for (int i = 0; i < `MBF_WIDTH; i++) begin
            w[i] = stepBit();
        end
        return w;
    endfunction

    function automatic logic [`COUNT_WIDTH-1:0] clampedOnes(input mbfWord w);
        mbfWord rest;
        int     n;
        rest = w;
        n = 0;
        while (rest != '0) begin
            rest = rest & (rest - `MBF_WIDTH'(1));  // drop lowest set bit
            n++;
        end
        if (n > (1 << `COUNT_WIDTH) - 1) begin
            n = (1 << `COUNT_WIDTH) - 1;
        end
        return `COUNT_WIDTH'(n);
    endfunction

    // kind prefix and two digits of the index
    function automatic logic [39:0] nameOf(input int kind, input int idx);
        logic [23:0] prefix;
        case (kind)
            kindTop: prefix = "top";
            kindSub: prefix = "sub";
            kindOut: prefix = "out";
            default: prefix = "nul";
        endcase
        return {prefix, 8'(48 + idx / 10), 8'(48 + idx % 10)};
    endfunction

    task automatic buildTable();
        mbfWord                  topWord;
        mbfWord                  word;
        logic [`SUM_WIDTH-1:0]   runSum;
        logic [`COUNT_WIDTH-1:0] count;
        int                      botsSinceTop;
        topWord = '0;
        runSum = '0;
        botsSinceTop = 0;
        for (int i = 0; i < numTests; i++) begin
            testName[i] = nameOf(kindPlan[i], i);
            topTable[i] = (kindPlan[i] == kindTop);
            expResult[i] = '0;
            case (kindPlan[i])
                kindTop: word = randomWord() & ~`MBF_WIDTH'(1);  // f(0) clear so out bots fit
                kindSub: word = topWord & randomWord();
                kindOut: word = (topWord & randomWord()) | `MBF_WIDTH'(1);
                default: word = '0;
            endcase
            wordTable[i] = word;
            if (topTable[i]) begin
                expTag[i] = tagTop;        // report of the previous top
                expResult[i].topReport.busyCycles = `CYCLE_WIDTH'(botsSinceTop);
                topWord = word;
                runSum = '0;
                botsSinceTop = 0;
            end else begin
                count = clampedOnes(topWord & ~word);
                runSum = runSum + `SUM_WIDTH'(count);
                expTag[i] = tagBot;
                // only an out bot carries f(0), which no top has
                expResult[i].botResult.eccStatus = (kindPlan[i] == kindOut);
                expResult[i].botResult.pcoeffCount = count;
                expResult[i].botResult.summedData = runSum;
                botsSinceTop++;
            end
        end
    endtask

    // every input change happens here on the falling edge
    task automatic nextCycle();
        @(negedge clock);
        outputReady = stepBit() | stepBit();
    endtask

    task automatic sendEntry(input int idx);
        int   waitCount;
        logic accepted;
        waitCount = 0;
        accepted = 1'b0;
        nextCycle();
        inputValid = 1'b1;
        startNewTop = topTable[idx];
        mbfIn = wordTable[idx];
        while (!accepted && !timedOut) begin
            @(posedge clock);
            if (inputReady) begin
                accepted = 1'b1;
            end else if (waitCount >= waitLimit) begin
                timedOut = 1'b1;
                $display("timeout, test %s was never accepted", testName[idx]);
            end else begin
                waitCount++;
                nextCycle();
            end
        end
    endtask

    task automatic drainOutputs();
        int waitCount;
        waitCount = 0;
        while (checkedCount < numTests && !timedOut) begin
            nextCycle();
            waitCount++;
            if (waitCount >= waitLimit) begin
                timedOut = 1'b1;
                $display("timeout, only %0d of %0d results arrived", checkedCount, numTests);
            end
        end
    endtask

    mbfPermutePipeline mbfPermutePipeline_i (
        .clock       (clock),
        .rst         (rst),
        .inputValid  (inputValid),
        .startNewTop (startNewTop),
        .mbfIn       (mbfIn),
        .inputReady  (inputReady),
        .outputValid (outputValid),
        .outputReady (outputReady),
        .result      (result),
        .tagOut      (tagOut)
    );

    tbChecker #(
        .numTests (numTests)
    ) tbChecker_i (
        .clock        (clock),
        .rst          (rst),
        .inputValid   (inputValid),
        .startNewTop  (startNewTop),
        .inputReady   (inputReady),
        .outputValid  (outputValid),
        .outputReady  (outputReady),
        .result       (result),
        .tagOut       (tagOut),
        .testName     (testName),
        .expResult    (expResult),
        .expTag       (expTag),
        .checkedCount (checkedCount),
        .errorCount   (errorCount)
    );

    initial begin
        clock = 1'b0;
        rst = 1'b0;
        inputValid = 1'b0;
        startNewTop = 1'b0;
        mbfIn = '0;
        outputReady = 1'b0;
        timedOut = 1'b0;
        buildTable();
        repeat (3) @(posedge clock);
        nextCycle();
        rst = 1'b1;
        inputValid = 1'b1;        // a bot before any top must stay waiting
        mbfIn = randomWord();
        repeat (6) nextCycle();
        for (int i = 0; i < numTests && !timedOut; i++) begin
            sendEntry(i);
        end
        nextCycle();
        inputValid = 1'b0;
        startNewTop = 1'b0;
        drainOutputs();
        repeat (8) nextCycle();   // room for any extra result to show up
        $display("checked %0d of %0d tests, %0d errors", checkedCount, numTests, errorCount);
        if (timedOut || errorCount != 0) begin
            $display("Finished with errors");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    end

endmodule

/* tbChecker.sv */
`timescale 1ns/1ns

module tbChecker
    import mbfTypesPkg::*;
    import pipeCtrlPkg::*;
#(
    parameter int numTests = 1
) (
    input  logic        clock,
    input  logic        rst,
    input  logic        inputValid,
    input  logic        startNewTop,
    input  logic        inputReady,
    input  logic        outputValid,
    input  logic        outputReady,
    input  pipeResult   result,
    input  stageTag     tagOut,
    input  logic [39:0] testName [numTests],
    input  pipeResult   expResult [numTests],
    input  stageTag     expTag [numTests],
    output int          checkedCount,
    output int          errorCount
);

    int   checkedNum = 0;
    int   errorNum = 0;
    logic topSeen = 1'b0;      // first top has passed the input
    logic idleFailed = 1'b0;

    assign checkedCount = checkedNum;
    assign errorCount   = errorNum;

    // before the first top nothing may enter and nothing may come out
    task automatic checkIdle();
        if (inputValid && inputReady && startNewTop) begin
            topSeen = 1'b1;
            $display("test idle: %s", idleFailed ? "failed" : "passed");
        end else if ((inputReady || outputValid) && !idleFailed) begin
            idleFailed = 1'b1;
            errorNum++;
            $display("before the first top inputReady is %b and outputValid is %b, both must be low",
                     inputReady, outputValid);
        end
    endtask

    // results are paired with table entries in order of arrival
    task automatic compareOutput();
        pipeResult expected;
        if (checkedNum >= numTests) begin
            errorNum++;
            $display("a result arrived after the last test, tag %0d", tagOut);
        end else begin
            expected = expResult[checkedNum];
            if (tagOut != expTag[checkedNum]) begin
                errorNum++;
                $display("ERROR test %s: expected tag %0d, actual tag %0d",
                         testName[checkedNum], expTag[checkedNum], tagOut);
            end else if (tagOut == tagTop &&
                         result.topReport.busyCycles != expected.topReport.busyCycles) begin
                errorNum++;
                $display("ERROR test %s: expected busyCycles %0d, actual %0d",
                         testName[checkedNum], expected.topReport.busyCycles,
                         result.topReport.busyCycles);
            end else if (tagOut == tagTop &&
                         result.topReport.totalCycles < result.topReport.busyCycles) begin
                errorNum++;
                $display("test %s: totalCycles %0d is smaller than busyCycles %0d",
                         testName[checkedNum], result.topReport.totalCycles,
                         result.topReport.busyCycles);
            end else if (tagOut == tagBot && result != expected) begin
                errorNum++;
                $display("ERROR test %s: expected %h, actual %h",
                         testName[checkedNum], expected, result);
            end else begin
                $display("test %s: passed", testName[checkedNum]);
            end
            checkedNum++;
        end
    endtask

    always @(posedge clock) begin
        if (rst) begin
            if (!topSeen) begin
                checkIdle();
            end
            if (outputValid && outputReady) begin  // transfer on this edge
                compareOutput();
            end
        end
    end

endmodule

/* mbfPermutePipeline.sv */
`timescale 1ns/1ns
`include "mbfPipe_defs.svh"

module mbfPermutePipeline
    import mbfTypesPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  logic      inputValid,
    input  logic      startNewTop,
    input  mbfWord    mbfIn,
    output logic      inputReady,
    output logic      outputValid,
    input  logic      outputReady,
    output pipeResult result,
    output stageTag   tagOut
);

    logic                    stageEnable;
    logic                    loadTop;
    logic                    clearCounts;
    logic                    botAccepted;
    logic [`CYCLE_WIDTH-1:0] busyCycles;
    logic [`CYCLE_WIDTH-1:0] totalCycles;
    logic                    notSubset;
    logic [`COUNT_WIDTH-1:0] pcoeffCount;
    stageTag                 inTag;
    stageTag                 compareTag;

    // anything not accepted this cycle enters stage 1 as a bubble
    always_comb begin
        if (!(inputValid && inputReady)) begin
            inTag = tagBubble;
        end else if (startNewTop) begin
            inTag = tagTop;
        end else begin
            inTag = tagBot;
        end
    end

    pipeFlowFsm pipeFlowFsm_i (
        .clock       (clock),
        .rst         (rst),
        .inputValid  (inputValid),
        .startNewTop (startNewTop),
        .outputValid (outputValid),
        .outputReady (outputReady),
        .inputReady  (inputReady),
        .stageEnable (stageEnable),
        .loadTop     (loadTop),
        .clearCounts (clearCounts),
        .botAccepted (botAccepted)
    );

    topCycleCounter topCycleCounter_i (
        .clock       (clock),
        .rst         (rst),
        .botAccepted (botAccepted),
        .clearCounts (clearCounts),
        .busyCycles  (busyCycles),
        .totalCycles (totalCycles)
    );

    bitCompareStage bitCompareStage_i (
        .clock       (clock),
        .rst         (rst),
        .stageEnable (stageEnable),
        .loadTop     (loadTop),
        .inWord      (mbfIn),
        .inTag       (inTag),
        .notSubset   (notSubset),
        .pcoeffCount (pcoeffCount),
        .tagOut      (compareTag)
    );

    sumAccumulator sumAccumulator_i (
        .clock       (clock),
        .rst         (rst),
        .stageEnable (stageEnable),
        .notSubset   (notSubset),
        .pcoeffCount (pcoeffCount),
        .tagIn       (compareTag),
        .busyCycles  (busyCycles),
        .totalCycles (totalCycles),
        .outputValid (outputValid),
        .result      (result),
        .tagOut      (tagOut)
    );

endmodule

/* sumAccumulator.sv */
`timescale 1ns/1ns
`include "mbfPipe_defs.svh"

module sumAccumulator
    import mbfTypesPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    stageEnable,
    input  logic                    notSubset,
    input  logic [`COUNT_WIDTH-1:0] pcoeffCount,
    input  stageTag                 tagIn,
    input  logic [`CYCLE_WIDTH-1:0] busyCycles,
    input  logic [`CYCLE_WIDTH-1:0] totalCycles,
    output logic                    outputValid,
    output pipeResult               result,
    output stageTag                 tagOut
);

    stageTag                 accTag;
    logic                    accNotSubset;
    logic [`COUNT_WIDTH-1:0] accCount;
    logic [`SUM_WIDTH-1:0]   runningSum;
    logic                    reportHeld;    // top stalled in stage 2
    logic [`CYCLE_WIDTH-1:0] heldBusy;
    logic [`CYCLE_WIDTH-1:0] heldTotal;
    pipeResult               nextResult;

    // stage 2 sum includes the bot now held in this stage
    always_ff @(posedge clock) begin
        if (!rst) begin
            accTag     <= tagBubble;
            runningSum <= '0;
        end else if (stageEnable) begin
            accTag <= tagIn;
            case (tagIn)
                tagTop:  runningSum <= '0;
                tagBot:  runningSum <= runningSum + `SUM_WIDTH'(pcoeffCount);
                default: runningSum <= runningSum;  // bubble
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (stageEnable) begin
            accNotSubset <= notSubset;
            accCount     <= pcoeffCount;
        end
    end

    // a stalled top keeps its report while the next top clears the counters
    always_ff @(posedge clock) begin
        if (!rst) begin
            reportHeld <= 1'b0;
        end else begin
            reportHeld <= !stageEnable && (accTag == tagTop);
        end
    end

    always_ff @(posedge clock) begin
        if (!reportHeld) begin
            heldBusy  <= busyCycles;
            heldTotal <= totalCycles;
        end
    end

    always_comb begin
        nextResult = '0;
        if (accTag == tagTop) begin
            // swap cycle snapshot or its copy taken while the top waits
            nextResult.topReport.busyCycles  = reportHeld ? heldBusy : busyCycles;
            nextResult.topReport.totalCycles = reportHeld ? heldTotal : totalCycles;
        end else begin
            nextResult.botResult.eccStatus   = accNotSubset;
            nextResult.botResult.pcoeffCount = accCount;
            nextResult.botResult.summedData  = runningSum;
        end
    end

    // stage 3 output register holds while the consumer stalls
    always_ff @(posedge clock) begin
        if (!rst) begin
            outputValid <= 1'b0;
            tagOut      <= tagBubble;
        end else if (stageEnable) begin
            outputValid <= (accTag != tagBubble);
            tagOut      <= accTag;
        end
    end

    always_ff @(posedge clock) begin
        if (stageEnable) begin
            result <= nextResult;
        end
    end

endmodule

/* bitCompareStage.sv */
`timescale 1ns/1ns
`include "mbfPipe_defs.svh"

module bitCompareStage
    import mbfTypesPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    stageEnable,
    input  logic                    loadTop,
    input  mbfWord                  inWord,
    input  stageTag                 inTag,
    output logic                    notSubset,
    output logic [`COUNT_WIDTH-1:0] pcoeffCount,
    output stageTag                 tagOut
);

    mbfWord                  topReg;
    mbfWord                  wordReg;       // last word taken in, source of the top load
    logic [`COUNT_WIDTH-1:0] missingCount;

    // number of set bits, clamped to the count field
    function automatic logic [`COUNT_WIDTH-1:0] popCount(input mbfWord w);
        int total;
        total = 0;
        for (int i = 0; i < `MBF_WIDTH; i++) begin
            total = total + int'(w[i]);
        end
        if (total >= (1 << `COUNT_WIDTH)) begin
            return '1;
        end
        return `COUNT_WIDTH'(total);
    endfunction

    assign missingCount = popCount(topReg & ~inWord);  // top bits the bot lacks

    always_ff @(posedge clock) begin
        if (!rst) begin
            tagOut <= tagBubble;
        end else if (stageEnable) begin
            tagOut <= inTag;
        end
    end

    always_ff @(posedge clock) begin
        if (stageEnable) begin
            wordReg     <= inWord;
            notSubset   <= |(inWord & ~topReg);     // a bit set outside the top
            pcoeffCount <= missingCount;
        end
        if (loadTop) begin
            topReg <= wordReg;  // still the top word during the swap cycle
        end
    end

endmodule

/* pipeFlowFsm.sv */
`timescale 1ns/1ns

module pipeFlowFsm
    import pipeCtrlPkg::*;
(
    input  logic clock,
    input  logic rst,
    input  logic inputValid,
    input  logic startNewTop,
    input  logic outputValid,
    input  logic outputReady,
    output logic inputReady,
    output logic stageEnable,
    output logic loadTop,
    output logic clearCounts,
    output logic botAccepted
);

    flowState state;
    flowState nextState;
    logic     inputAccept;

    // all stages move together unless the output register is stuck
    assign stageEnable = !outputValid || outputReady;
    assign inputAccept = inputValid && inputReady;
    assign botAccepted = inputAccept && !startNewTop;

    assign loadTop     = (state == stateSwap);
    assign clearCounts = (state == stateSwap);  // report snapshot in the same cycle

    always_comb begin
        nextState  = state;
        inputReady = 1'b0;
        case (state)
            stateIdle: begin
                // bots before the first top are left waiting
                inputReady = stageEnable && inputValid && startNewTop;
                if (inputAccept) begin
                    nextState = stateSwap;
                end
            end
            stateRun: begin
                inputReady = stageEnable;
                if (inputAccept && startNewTop) begin
                    nextState = stateSwap;
                end
            end
            stateSwap: begin
                nextState = stateRun;       // exactly one bubble
            end
            default: begin
                nextState = stateIdle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            state <= stateIdle;
        end else begin
            state <= nextState;
        end
    end

endmodule

/* topCycleCounter.sv */
`timescale 1ns/1ns
`include "mbfPipe_defs.svh"

module topCycleCounter (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    botAccepted,
    input  logic                    clearCounts,
    output logic [`CYCLE_WIDTH-1:0] busyCycles,
    output logic [`CYCLE_WIDTH-1:0] totalCycles
);

    logic [`CYCLE_WIDTH-1:0] busyCount;
    logic [`CYCLE_WIDTH-1:0] totalCount;
    logic                    busyFull;
    logic                    totalFull;

    assign busyFull  = &busyCount;   // saturate instead of wrapping
    assign totalFull = &totalCount;

    always_ff @(posedge clock) begin
        if (!rst) begin
            busyCount   <= '0;
            totalCount  <= '0;
            busyCycles  <= '0;
            totalCycles <= '0;
        end else if (clearCounts) begin
            // snapshot for the report, then start over for the new top
            busyCycles  <= busyCount;
            totalCycles <= totalCount;
            busyCount   <= '0;
            totalCount  <= `CYCLE_WIDTH'(1);  // swap cycle belongs to the new top
        end else begin
            if (botAccepted && !busyFull) begin
                busyCount <= busyCount + 1'b1;
            end
            if (!totalFull) begin
                totalCount <= totalCount + 1'b1;
            end
        end
    end

endmodule

/* pipeCtrlPkg.sv */
package pipeCtrlPkg;

    // input side flow control
    typedef enum logic [1:0] {
        stateIdle,  // waiting for the first top
        stateRun,   // bots and tops accepted
        stateSwap   // bubble after a top, top register loads
    } flowState;

    // kind of item held by a pipeline stage
    typedef enum logic [1:0] {
        tagBubble,
        tagBot,
        tagTop      // also carries the previous top's report
    } stageTag;

endpackage

/* mbfTypesPkg.sv */
`include "mbfPipe_defs.svh"

package mbfTypesPkg;

    // truth table of one function, bit i is f(i)
    typedef logic [`MBF_WIDTH-1:0] mbfWord;

    // a result word is read as a bot result or as a top report,
    // the tag travelling next to it says which
    typedef union packed {
        struct packed {
            logic                    eccStatus;   // bot not a subset of top
            logic [`SPARE_WIDTH-1:0] spare;
            logic [`COUNT_WIDTH-1:0] pcoeffCount;
            logic [`SUM_WIDTH-1:0]   summedData;
        } botResult;
        struct packed {
            logic [`CYCLE_WIDTH-1:0] busyCycles;   // accepted bots of previous top
            logic [`CYCLE_WIDTH-1:0] totalCycles;  // all cycles of previous top
        } topReport;
    } pipeResult;

endpackage

/* mbfPipe_defs.svh */
`ifndef MBF_PIPE_DEFS_SVH
`define MBF_PIPE_DEFS_SVH

// one 7-input monotone function as a truth table
`define MBF_WIDTH 128

// coefficient count of a single bot
`define COUNT_WIDTH 13

// running sum over all bots of one top
`define SUM_WIDTH 48

// one result word on the output port
`define RESULT_WIDTH 64

// each occupancy counter, two of them fill a result word
`define CYCLE_WIDTH 32

// unused bits between eccStatus and pcoeffCount
`define SPARE_WIDTH (`RESULT_WIDTH - 1 - `COUNT_WIDTH - `SUM_WIDTH)

`endif
